/* tb.f */
source/cache_pkg.sv
source/mem_pkg.sv
source/line_array.sv
source/hit_compare.sv
source/plru_tree.sv
source/line_write_mux.sv
source/cache_fsm.sv
source/mutative_cache.sv
tests/mem_model.sv
tests/cache_tb.sv

/* Bender.yml */
package:
  name: mutative_cache

sources:
  - source/cache_pkg.sv
  - source/mem_pkg.sv
  - source/line_array.sv
  - source/hit_compare.sv
  - source/plru_tree.sv
  - source/line_write_mux.sv
  - source/cache_fsm.sv
  - source/mutative_cache.sv
  - target: test
    files:
      - tests/mem_model.sv
      - tests/cache_tb.sv

/* tests/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb
    import cache_pkg::*;
    import mem_pkg::*;
();

    localparam int          MEM_DELAY    = 4;
    localparam int          MEM_LINES    = 256;
    localparam logic [31:0] SEED         = 32'h08fd_4b62;
    localparam int          RESP_TIMEOUT = 100;
    localparam int          RANDOM_OPS   = 200;

    logic        clk, rst;
    assoc_mode_t assoc_mode;
    addr_t       ufp_addr, dfp_addr;
    byte_mask_t  ufp_rmask, ufp_wmask;
    word_t       ufp_wdata, ufp_rdata;
    logic        ufp_resp, dfp_read, dfp_write, dfp_resp;
    line_t       dfp_rdata, dfp_wdata;

    int          read_count, write_count;
    addr_t       last_raddr, last_waddr;
    line_t       last_wline;
    logic        range_error;

    line_t       ref_mem [MEM_LINES];   // expected memory image
    logic [31:0] rand_state;
    string       test_name;
    int          checks, errors, test_errors, tests_run, last_cycles;
    logic        timed_out;

    mutative_cache mutative_cache_i (.*);

    mem_model #(
        .DELAY (MEM_DELAY),
        .LINES (MEM_LINES),
        .SEED  (SEED)
    ) mem_model_i (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic addr_t make_addr(input int tag, input int set, input int word);
        return addr_t'((tag << (SET_BITS + OFFSET_BITS)) | (set << OFFSET_BITS) | (word << 2));
    endfunction

    function automatic word_t ref_word(input addr_t a);
        return ref_mem[int'(a >> OFFSET_BITS)][int'(a[4:2]) * WORD_BITS +: WORD_BITS];
    endfunction

    task automatic store_ref(input addr_t a, input byte_mask_t mask, input word_t data);
        int base;
        base = int'(a[4:2]) * WORD_BITS;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) ref_mem[int'(a >> OFFSET_BITS)][base + b*8 +: 8] = data[b*8 +: 8];
        end
    endtask

    // tree bits after an access with each path bit turned away from the way
    function automatic logic [2:0] tree_after_access(input logic [2:0] tree, input int way);
        logic [2:0] next;
        next    = tree;
        next[0] = (way < 2);
        if (way < 2) next[1] = (way == 0);
        else next[2] = (way == 2);
        return next;
    endfunction

    function automatic int predict_victim(input logic [2:0] tree, input assoc_mode_t mode,
                                          input int tag);
        if (mode == MODE_DIRECT) return tag % 4;
        if (mode == MODE_TWO) return (tag % 2 == 1) ? 2 + int'(tree[2]) : int'(tree[1]);
        return tree[0] ? 2 + int'(tree[2]) : int'(tree[1]);
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            test_errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            test_errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_line(input string what, input line_t exp, input line_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            test_errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            test_errors++;
            $display("** Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic reset_dut(input assoc_mode_t mode);
        rst        = 1'b1;
        assoc_mode = mode;   // mode only changes while in reset
        ufp_rmask  = '0;
        ufp_wmask  = '0;
        repeat (3) @(posedge clk);
        #2 rst = 1'b0;
    endtask

    // one cpu request entered 2 ns after a rising edge in an idle cycle
    task automatic cpu_request(input addr_t addr, input byte_mask_t rmask,
                               input byte_mask_t wmask, input word_t wdata,
                               output word_t rdata);
        int n;
        rdata = '0;
        if (timed_out) return;
        ufp_addr  = addr;
        ufp_rmask = rmask;
        ufp_wmask = wmask;
        ufp_wdata = wdata;
        @(posedge clk);
        #2;
        ufp_rmask = '0;   // drop the request once registered
        ufp_wmask = '0;
        @(negedge clk);
        n = 1;
        while (!ufp_resp && n < RESP_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!ufp_resp) begin
            $display("%s: no ufp_resp within %0d cycles, stopping", test_name, RESP_TIMEOUT);
            timed_out = 1'b1;
            errors++;
            test_errors++;
            return;
        end
        rdata       = ufp_rdata;
        last_cycles = n;
        @(posedge clk);
        #2;
    endtask

    task automatic read_and_check(input addr_t addr, input int new_reads, input string what);
        word_t data;
        int    r0;
        r0 = read_count;
        cpu_request(addr, 4'hf, 4'h0, '0, data);
        check_word(what, ref_word(addr), data);
        check_count({what, " memory reads"}, new_reads, read_count - r0);
    endtask

    task automatic write_word(input addr_t addr, input byte_mask_t mask, input word_t data);
        word_t unused;
        cpu_request(addr, 4'h0, mask, data, unused);
        store_ref(addr, mask, data);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) $display("%s: pass", test_name);
        else $display("%s: fail, %0d mismatches", test_name, test_errors);
    endtask

    task automatic test_read_miss_hit();
        addr_t a;
        int    w0;
        start_test("read_miss_hit");
        reset_dut(MODE_FOUR);
        a  = make_addr(3, 1, 5);
        w0 = write_count;
        read_and_check(a, 1, "miss read");
        check_addr("refill address", {a[31:5], 5'b0}, last_raddr);
        check_count("miss latency", MEM_DELAY + 3, last_cycles);
        read_and_check(a, 0, "hit read");
        check_count("hit latency", 1, last_cycles);
        check_count("memory writes", 0, write_count - w0);
        finish_test();
    endtask

    task automatic test_partial_write();
        addr_t a;
        word_t old, data;
        start_test("partial_write");
        reset_dut(MODE_FOUR);
        a   = make_addr(2, 2, 3);
        old = ref_word(a);
        write_word(a, 4'b0101, 32'ha5c3_5a3c);
        cpu_request(a, 4'hf, 4'h0, '0, data);
        check_word("merged word", {old[31:24], 8'hc3, old[15:8], 8'h3c}, data);
        read_and_check(make_addr(2, 2, 4), 0, "neighbour word");
        finish_test();
    endtask

    task automatic test_dirty_evict_direct();
        addr_t a, b;
        int    w0;
        start_test("dirty_evict_direct");
        reset_dut(MODE_DIRECT);
        a = make_addr(1, 3, 2);   // tags 1 and 5 share way 1
        b = make_addr(5, 3, 6);
        write_word(a, 4'hf, 32'h1357_9bdf);
        w0 = write_count;
        read_and_check(b, 1, "evicting read");
        check_count("writebacks", 1, write_count - w0);
        check_addr("writeback address", {a[31:5], 5'b0}, last_waddr);
        check_line("writeback line", ref_mem[int'(a >> OFFSET_BITS)], last_wline);
        read_and_check(a, 1, "reread after writeback");
        check_count("clean eviction writes", 1, write_count - w0);
        finish_test();
    endtask

    task automatic test_plru_four_way();
        addr_t      addrs [5];
        logic [2:0] tree;
        int         victim;
        start_test("plru_four_way");
        reset_dut(MODE_FOUR);
        tree = '0;
        for (int i = 0; i < 5; i++) addrs[i] = make_addr(6 + i, 4, i);
        for (int i = 0; i < 4; i++) begin
            read_and_check(addrs[i], 1, "fill read");
            tree = tree_after_access(tree, i);   // empty ways fill from way 0 up
        end
        read_and_check(addrs[0], 0, "way 0 touch");
        tree   = tree_after_access(tree, 0);
        victim = predict_victim(tree, MODE_FOUR, 10);
        read_and_check(addrs[4], 1, "fifth tag");
        for (int i = 0; i < 4; i++) begin
            if (i != victim) read_and_check(addrs[i], 0, "survivor");
        end
        read_and_check(addrs[victim], 1, "predicted victim");
        finish_test();
    endtask

    task automatic test_two_way_placement();
        addr_t      odd_a;
        logic [2:0] tree;
        int         victim, kept, evicted;
        start_test("two_way_placement");
        reset_dut(MODE_TWO);
        odd_a = make_addr(7, 5, 1);
        read_and_check(odd_a, 1, "odd tag fill");
        tree = tree_after_access('0, 2);   // odd tags live in ways 2/3
        read_and_check(make_addr(4, 5, 2), 1, "tag 4 fill");
        tree = tree_after_access(tree, 0);
        read_and_check(odd_a, 0, "odd tag kept");
        tree = tree_after_access(tree, 2);
        read_and_check(make_addr(6, 5, 3), 1, "tag 6 fill");
        tree = tree_after_access(tree, 1);
        read_and_check(make_addr(4, 5, 0), 0, "tag 4 touch");
        tree = tree_after_access(tree, 0);
        read_and_check(odd_a, 0, "odd tag kept");
        tree    = tree_after_access(tree, 2);
        victim  = predict_victim(tree, MODE_TWO, 8);
        evicted = (victim == 0) ? 4 : 6;
        kept    = (victim == 0) ? 6 : 4;
        read_and_check(make_addr(8, 5, 4), 1, "tag 8 fill");
        read_and_check(odd_a, 0, "odd tag kept");
        read_and_check(make_addr(kept, 5, 5), 0, "even survivor");
        read_and_check(make_addr(8, 5, 6), 0, "tag 8 resident");
        read_and_check(make_addr(evicted, 5, 7), 1, "even victim");
        finish_test();
    endtask

    task automatic test_random_mix();
        logic [31:0] r;
        addr_t       a;
        byte_mask_t  mask;
        word_t       data;
        start_test("random_mix");
        reset_dut(MODE_FOUR);
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = next_rand();
            a = make_addr(int'(r[6:3]), 8 + int'(r[2:0]), int'(r[9:7]));   // sets 8..15
            if (r[10]) begin
                mask = (r[14:11] == 4'h0) ? 4'hf : r[14:11];
                write_word(a, mask, next_rand());
            end else begin
                cpu_request(a, 4'hf, 4'h0, '0, data);
                check_word("random read", ref_word(a), data);
            end
        end
        finish_test();
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        assoc_mode  = MODE_FOUR;
        ufp_addr    = '0;
        ufp_rmask   = '0;
        ufp_wmask   = '0;
        ufp_wdata   = '0;
        checks      = 0;
        errors      = 0;
        tests_run   = 0;
        last_cycles = 0;
        timed_out   = 1'b0;
        rand_state  = SEED;
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int w = 0; w < LINE_BITS / WORD_BITS; w++) begin
                ref_mem[l][w*WORD_BITS +: WORD_BITS] = next_rand();
            end
        end

        // each test owns its sets so dirty lines lost at reset never matter
        test_read_miss_hit();
        if (!timed_out) test_partial_write();
        if (!timed_out) test_dirty_evict_direct();
        if (!timed_out) test_plru_four_way();
        if (!timed_out) test_two_way_placement();
        if (!timed_out) test_random_mix();

        if (range_error) begin
            errors++;
            $display("memory model saw an access outside its %0d lines", MEM_LINES);
        end
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* tests/mem_model.sv */
`timescale 1ns/1ps

module mem_model
    import cache_pkg::*;
    import mem_pkg::*;
#(
    parameter int          DELAY = 4,
    parameter int          LINES = 256,
    parameter logic [31:0] SEED  = 32'h08fd_4b62
) (
    input  logic  clk,
    input  logic  rst,
    input  addr_t dfp_addr,
    input  logic  dfp_read,
    input  logic  dfp_write,
    input  line_t dfp_wdata,
    output line_t dfp_rdata,
    output logic  dfp_resp,
    output int    read_count,
    output int    write_count,
    output addr_t last_raddr,
    output addr_t last_waddr,
    output line_t last_wline,
    output logic  range_error
);

    line_t       mem [LINES];
    int          wait_cnt;
    int          idx;
    logic        in_range;
    logic [31:0] state;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        state       = SEED;
        dfp_rdata   = '0;
        dfp_resp    = 1'b0;
        read_count  = 0;
        write_count = 0;
        range_error = 1'b0;
        wait_cnt    = 0;
        for (int l = 0; l < LINES; l++) begin
            for (int w = 0; w < LINE_BITS / WORD_BITS; w++) begin
                state = lcg_step(state);
                mem[l][w*WORD_BITS +: WORD_BITS] = state;   // whole line from the lcg
            end
        end
    end

    assign idx      = int'(dfp_addr >> OFFSET_BITS);
    assign in_range = idx < LINES;

    // one transaction per request, answered DELAY edges after it shows up
    always @(posedge clk) begin
        dfp_resp <= 1'b0;
        if (rst) begin
            wait_cnt <= 0;
        end else if ((dfp_read || dfp_write) && !dfp_resp) begin
            if (wait_cnt == DELAY - 1) begin
                wait_cnt <= 0;
                dfp_resp <= 1'b1;
                if (!in_range) begin
                    range_error <= 1'b1;
                end else if (dfp_write) begin
                    mem[idx]    <= dfp_wdata;
                    write_count <= write_count + 1;
                    last_waddr  <= dfp_addr;
                    last_wline  <= dfp_wdata;
                end else begin
                    dfp_rdata  <= mem[idx];
                    read_count <= read_count + 1;
                    last_raddr <= dfp_addr;
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

endmodule

/* source/mutative_cache.sv */
`timescale 1ns/1ps

module mutative_cache
    import cache_pkg::*;
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  assoc_mode_t assoc_mode,
    // cpu side
    input  addr_t       ufp_addr,
    input  byte_mask_t  ufp_rmask,
    input  byte_mask_t  ufp_wmask,
    input  word_t       ufp_wdata,
    output word_t       ufp_rdata,
    output logic        ufp_resp,
    // memory side
    output addr_t       dfp_addr,
    output logic        dfp_read,
    output logic        dfp_write,
    input  line_t       dfp_rdata,
    output line_t       dfp_wdata,
    input  logic        dfp_resp
);

    addr_t      req_addr;
    byte_mask_t req_wmask;
    word_t      req_wdata;
    line_t      refill_q;
    logic       idle, request, wen, fill, plru_touch, hit;
    tag_t       req_tag;
    set_idx_t   req_set;
    offset_t    req_offset;

    tag_t  [WAYS-1:0] way_tags;
    line_t [WAYS-1:0] way_lines;
    way_mask_t        way_valids, way_dirties, way_wen, allowed;
    way_idx_t         hit_way, victim_way, target_way;
    line_t            wline;
    line_be_t         be;
    logic             wdirty;

    assign request = |ufp_rmask || |ufp_wmask;

    // request captured on acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            req_wmask <= '0;
        end else if (idle) begin
            req_wmask <= ufp_wmask;
        end
    end

    always_ff @(posedge clk) begin
        if (idle) begin
            req_addr  <= ufp_addr;
            req_wdata <= ufp_wdata;
        end
        if (dfp_read && dfp_resp) begin
            refill_q <= dfp_rdata;   // written into the way next cycle
        end
    end

    assign req_tag    = req_addr[ADDR_BITS-1 -: TAG_BITS];
    assign req_set    = req_addr[OFFSET_BITS +: SET_BITS];
    assign req_offset = req_addr[OFFSET_BITS-1:0];

    assign target_way = fill ? victim_way : hit_way;

    for (genvar i = 0; i < WAYS; i++) begin : g_way
        assign way_wen[i] = wen && (target_way == way_idx_t'(i));

        line_array line_array_i (
            .clk       (clk),
            .rst       (rst),
            .set_idx   (req_set),
            .wen       (way_wen[i]),
            .set_valid (fill),
            .be        (be),
            .wline     (wline),
            .wtag      (req_tag),
            .wdirty    (wdirty),
            .rtag      (way_tags[i]),
            .rdirty    (way_dirties[i]),
            .rvalid    (way_valids[i]),
            .rline     (way_lines[i])
        );
    end

    hit_compare hit_compare_i (
        .mode    (assoc_mode),
        .tag     (req_tag),
        .offset  (req_offset),
        .tags    (way_tags),
        .valids  (way_valids),
        .lines   (way_lines),
        .allowed (allowed),
        .hit     (hit),
        .hit_way (hit_way),
        .rdata   (ufp_rdata)
    );

    plru_tree plru_tree_i (
        .clk        (clk),
        .rst        (rst),
        .set_idx    (req_set),
        .mode       (assoc_mode),
        .tag_low    (req_tag[1:0]),
        .allowed    (allowed),
        .valids     (way_valids),
        .touch      (plru_touch),
        .touch_way  (hit_way),
        .victim_way (victim_way)
    );

    line_write_mux line_write_mux_i (
        .fill        (fill),
        .refill_line (refill_q),
        .wdata       (req_wdata),
        .wmask       (req_wmask),
        .offset      (req_offset),
        .wline       (wline),
        .be          (be),
        .wdirty      (wdirty)
    );

    cache_fsm cache_fsm_i (
        .clk          (clk),
        .rst          (rst),
        .request      (request),
        .is_write     (|req_wmask),
        .hit          (hit),
        .victim_dirty (way_dirties[victim_way]),
        .victim_valid (way_valids[victim_way]),
        .dfp_resp     (dfp_resp),
        .idle         (idle),
        .ufp_resp     (ufp_resp),
        .dfp_read     (dfp_read),
        .dfp_write    (dfp_write),
        .fill         (fill),
        .wen          (wen),
        .plru_touch   (plru_touch)
    );

    // victim line address on writeback, request line otherwise
    assign dfp_addr = dfp_write
        ? {way_tags[victim_way], req_set, {OFFSET_BITS{1'b0}}}
        : {req_addr[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign dfp_wdata = way_lines[victim_way];

endmodule

/* source/cache_fsm.sv */
`timescale 1ns/1ps

module cache_fsm
    import mem_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic request,
    input  logic is_write,
    input  logic hit,
    input  logic victim_dirty,
    input  logic victim_valid,
    input  logic dfp_resp,
    output logic idle,
    output logic ufp_resp,
    output logic dfp_read,
    output logic dfp_write,
    output logic fill,
    output logic wen,
    output logic plru_touch
);

    cache_state_t state, state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        ufp_resp   = 1'b0;
        dfp_read   = 1'b0;
        dfp_write  = 1'b0;
        fill       = 1'b0;
        wen        = 1'b0;
        plru_touch = 1'b0;
        case (state)
            s_idle: begin
                if (request) state_next = s_compare;
            end
            s_compare: begin
                if (hit) begin
                    ufp_resp   = 1'b1;
                    plru_touch = 1'b1;
                    wen        = is_write;   // store merge into the hit way
                    state_next = s_idle;
                end else if (victim_valid && victim_dirty) begin
                    dfp_write  = 1'b1;
                    state_next = s_writeback;
                end else begin
                    dfp_read   = 1'b1;
                    state_next = s_refill;
                end
            end
            s_writeback: begin
                dfp_write = 1'b1;
                if (dfp_resp) state_next = s_refill;
            end
            s_refill: begin
                dfp_read = 1'b1;
                if (dfp_resp) state_next = s_fill_write;
            end
            s_fill_write: begin
                fill       = 1'b1;
                wen        = 1'b1;
                state_next = s_compare;   // redo the lookup, now a hit
            end
            default: state_next = s_idle;
        endcase
    end

    assign idle = (state == s_idle);

endmodule

/* source/line_write_mux.sv */
`timescale 1ns/1ps

module line_write_mux
    import cache_pkg::*;
    import mem_pkg::*;
(
    input  logic       fill,
    input  line_t      refill_line,
    input  word_t      wdata,
    input  byte_mask_t wmask,
    input  offset_t    offset,
    output line_t      wline,
    output line_be_t   be,
    output logic       wdirty
);

    localparam int WORDS_PER_LINE = LINE_BITS / WORD_BITS;

    logic [OFFSET_BITS-3:0] word_sel;

    assign word_sel = offset[OFFSET_BITS-1:2];

    always_comb begin
        if (fill) begin
            wline  = refill_line;   // whole line, clean
            be     = '1;
            wdirty = 1'b0;
        end else begin
            // store: word copied to every slot, enables pick the target bytes
            wline  = {WORDS_PER_LINE{wdata}};
            be     = line_be_t'(wmask) << (word_sel * WORD_BYTES);
            wdirty = 1'b1;
        end
    end

endmodule

/* source/plru_tree.sv */
`timescale 1ns/1ps

module plru_tree
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  set_idx_t    set_idx,
    input  assoc_mode_t mode,
    input  logic [1:0]  tag_low,
    input  way_mask_t   allowed,
    input  way_mask_t   valids,
    input  logic        touch,
    input  way_idx_t    touch_way,
    output way_idx_t    victim_way
);

    // bit 0 picks the pair, bit 1 within ways 0/1, bit 2 within ways 2/3
    logic [2:0] tree_q [SETS];
    logic [2:0] bits;
    way_mask_t  empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch) begin
            tree_q[set_idx][0] <= ~touch_way[1];   // point at the other pair
            if (touch_way[1]) begin
                tree_q[set_idx][2] <= ~touch_way[0];
            end else begin
                tree_q[set_idx][1] <= ~touch_way[0];
            end
        end
    end

    assign bits  = tree_q[set_idx];
    assign empty = allowed & ~valids;

    always_comb begin
        victim_way = '0;
        if (|empty) begin
            // fill free ways first, lowest number first
            for (int i = WAYS - 1; i >= 0; i--) begin
                if (empty[i]) begin
                    victim_way = way_idx_t'(i);
                end
            end
        end else begin
            case (mode)
                MODE_DIRECT: victim_way = tag_low;
                MODE_TWO: begin
                    // pair fixed by tag bit 0
                    victim_way = tag_low[0] ? {1'b1, bits[2]} : {1'b0, bits[1]};
                end
                default: begin
                    victim_way = bits[0] ? {1'b1, bits[2]} : {1'b0, bits[1]};
                end
            endcase
        end
    end

endmodule

/* source/hit_compare.sv */
`timescale 1ns/1ps

module hit_compare
    import cache_pkg::*;
    import mem_pkg::*;
(
    input  assoc_mode_t          mode,
    input  tag_t                 tag,
    input  offset_t              offset,
    input  tag_t  [WAYS-1:0]     tags,
    input  way_mask_t            valids,
    input  line_t [WAYS-1:0]     lines,
    output way_mask_t            allowed,
    output logic                 hit,
    output way_idx_t             hit_way,
    output word_t                rdata
);

    way_mask_t match;

    // ways that may hold this tag under the current mode
    always_comb begin
        case (mode)
            MODE_DIRECT: allowed = way_mask_t'(1) << tag[1:0];
            MODE_TWO:    allowed = tag[0] ? 4'b1100 : 4'b0011;
            default:     allowed = '1;
        endcase
    end

    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            match[i] = allowed[i] && valids[i] && (tags[i] == tag);
        end
    end

    assign hit = |match;

    // lowest matching way wins, only one can match in practice
    always_comb begin
        hit_way = '0;
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_way = way_idx_t'(i);
            end
        end
    end

    // word select from the hitting line
    assign rdata = lines[hit_way][offset[OFFSET_BITS-1:2]*WORD_BITS +: WORD_BITS];

endmodule

/* source/line_array.sv */
`timescale 1ns/1ps

module line_array
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  set_idx_t set_idx,
    input  logic     wen,
    input  logic     set_valid,
    input  line_be_t be,
    input  line_t    wline,
    input  tag_t     wtag,
    input  logic     wdirty,
    output tag_t     rtag,
    output logic     rdirty,
    output logic     rvalid,
    output line_t    rline
);

    line_t            data_q  [SETS];
    tag_t             tag_q   [SETS];
    logic [SETS-1:0]  dirty_q;
    logic [SETS-1:0]  valid_q;

    // payload storage, byte granular
    always_ff @(posedge clk) begin
        if (wen) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (be[b]) begin
                    data_q[set_idx][b*8 +: 8] <= wline[b*8 +: 8];
                end
            end
            tag_q[set_idx]   <= wtag;
            dirty_q[set_idx] <= wdirty;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wen && set_valid) begin
            valid_q[set_idx] <= 1'b1;
        end
    end

    // asynchronous read of the indexed entry
    assign rline  = data_q[set_idx];
    assign rtag   = tag_q[set_idx];
    assign rdirty = dirty_q[set_idx];
    assign rvalid = valid_q[set_idx];

endmodule

/* source/mem_pkg.sv */
package mem_pkg;

    // cpu and memory bus widths
    localparam int ADDR_BITS  = 32;
    localparam int WORD_BITS  = 32;
    localparam int WORD_BYTES = WORD_BITS / 8;

    typedef logic [ADDR_BITS-1:0]  addr_t;
    typedef logic [WORD_BITS-1:0]  word_t;
    typedef logic [WORD_BYTES-1:0] byte_mask_t;   // one bit per byte lane

    // controller sequence
    typedef enum logic [2:0] {
        s_idle,
        s_compare,     // tag lookup on the registered request
        s_writeback,   // dirty victim out to memory
        s_refill,      // line read from memory
        s_fill_write   // refill line into the victim way
    } cache_state_t;

endpackage

/* source/cache_pkg.sv */
package cache_pkg;

    // cache geometry
    localparam int WAYS        = 4;   // physical ways
    localparam int WAY_BITS    = 2;
    localparam int SET_BITS    = 4;
    localparam int SETS        = 16;
    localparam int OFFSET_BITS = 5;   // byte offset within a line
    localparam int TAG_BITS    = 23;
    localparam int LINE_BITS   = 256;
    localparam int LINE_BYTES  = LINE_BITS / 8;

    // associativity encodings seen on assoc_mode
    localparam logic [1:0] MODE_DIRECT = 2'd0;
    localparam logic [1:0] MODE_TWO    = 2'd1;
    localparam logic [1:0] MODE_FOUR   = 2'd2;   // 3 behaves the same

    // address fields
    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [SET_BITS-1:0]    set_idx_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;

    // way selection
    typedef logic [WAY_BITS-1:0]    way_idx_t;
    typedef logic [WAYS-1:0]        way_mask_t;

    // line payload and its byte enables
    typedef logic [LINE_BITS-1:0]   line_t;
    typedef logic [LINE_BYTES-1:0]  line_be_t;

    typedef logic [1:0]             assoc_mode_t;

endpackage
